// File: all.f
+incdir+include
verilog/sysctl_cfg_pkg.sv
verilog/board_io_pkg.sv
verilog/clock_enable_gen.sv
verilog/boot_sequencer.sv
verilog/board_io.sv
verilog/pcxt_sysctl.sv
test/tb_pcxt_sysctl.sv

// File: Bender.yml
package:
  name: pcxt_sysctl

sources:
  - files:
      - verilog/sysctl_cfg_pkg.sv
      - verilog/board_io_pkg.sv
      - verilog/clock_enable_gen.sv
      - verilog/boot_sequencer.sv
      - verilog/board_io.sv
      - verilog/pcxt_sysctl.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/tb_pcxt_sysctl.sv

// File: include/tb_sysctl_model.svh
// Reference model for the system control testbench
// Expected values worked out from the documented behavior,
// plus the single compare task that counts mismatches

`ifndef TB_SYSCTL_MODEL_SVH
`define TB_SYSCTL_MODEL_SVH

// Pulses of a channel at rate_hz after a number of cycles from reset
function automatic int expected_pulses(input int cycles, input int rate_hz, input int clk_hz);
	longint total;
	total = longint'(cycles) * longint'(rate_hz);
	return int'(total / longint'(clk_hz));
endfunction

// Turbo lamp lit for any speed above base with the reserved code at base
function automatic logic expected_turbo(input cpu_speed_e speed);
	cpu_speed_e effective;
	if (speed == SPEED_RSVD) begin
		effective = SPEED_4_77;
	end else begin
		effective = speed;
	end
	return effective != SPEED_4_77;
endfunction

// Port C low nibble from the switch bank of the adapter
function automatic logic [3:0] dip_nibble(input logic video_mda, input logic pb3);
	logic [7:0] bank;
	bank = video_mda ? 8'h3D : 8'h2D;
	return pb3 ? bank[7:4] : bank[3:0];
endfunction

// Code 0 is 4:3, otherwise the code minus one on X and zero on Y
function automatic logic [12:0] aspect_x(input logic [1:0] code);
	return (code == 2'd0) ? 13'd4 : 13'(int'(code) - 1);
endfunction

function automatic logic [12:0] aspect_y(input logic [1:0] code);
	return (code == 2'd0) ? 13'd3 : 13'd0;
endfunction

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
	check_count++;
	if (got !== exp) begin
		value_errors++;
		$display("** Error at time %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
	end
endtask

`endif

// File: test/tb_pcxt_sysctl.sv
// Testbench for the PC/XT system control top level
// Boot timing, splash skip, strobe counts, speed application,
// board glue and LED stretch, driven from an xorshift stream

`timescale 1ns/1ps

module tb_pcxt_sysctl;

	import sysctl_cfg_pkg::*;
	import board_io_pkg::*;

	// Small rates keep the boot sequence short
	localparam int CLK_HZ           = 1000;
	localparam int CPU_HZ_SLOW      = 300;
	localparam int SYS_RESET_CYCLES = 16;
	localparam int CPU_RESET_CYCLES = 42;
	localparam int SPLASH_SECONDS   = 2;
	localparam int LED_HOLD_CYCLES  = 20;
	localparam int SPLASH_CYCLES    = SPLASH_SECONDS * CLK_HZ;

	localparam int RESET_CYCLES  = 10;
	localparam int SKIP_MAX      = 400;
	localparam int WINDOW_MIN    = 50;
	localparam int WINDOW_MAX    = 600;
	localparam int RANDOM_CYCLES = 800;
	localparam logic [31:0] RNG_SEED = 32'hfe1a_12c4;

	// Sum of all phases plus some slack
	localparam int BOOT_CYCLES     = SYS_RESET_CYCLES + SPLASH_CYCLES + CPU_RESET_CYCLES;
	localparam int SKIP_CYCLES     = SYS_RESET_CYCLES + SKIP_MAX + 1 + CPU_RESET_CYCLES;
	localparam int PHASE_OVERHEAD  = RESET_CYCLES + 4;
	localparam int WATCHDOG_CYCLES = 4 * PHASE_OVERHEAD + BOOT_CYCLES + SKIP_CYCLES
	                                 + WINDOW_MAX + RANDOM_CYCLES + 200;

	// Selectors for the falling-edge wait
	localparam int FALL_SYS_RESET = 0;
	localparam int FALL_SPLASH    = 1;
	localparam int FALL_CPU_RESET = 2;

	logic                 CLK_50M;
	logic                 reset_wire;
	logic [31:0]          status;
	logic                 bus_idle;
	logic                 disk_activity;
	logic                 port_b_bit3;
	ps2_lines_t           ps2_kbd_in;
	joy_port_t            joy_in_0;
	joy_port_t            joy_in_1;
	logic                 ce_cpu;
	logic                 ce_periph;
	logic                 ce_audio;
	logic                 turbo;
	cpu_speed_e           cpu_speed;
	logic                 sys_reset;
	logic                 cpu_reset;
	logic                 splash_active;
	machine_model_e       model;
	ps2_lines_t           ps2_kbd_sync;
	logic [3:0]           port_c_low;
	joy_port_t            joy_out_0;
	joy_port_t            joy_out_1;
	logic [ASPECT_W-1:0]  video_arx;
	logic [ASPECT_W-1:0]  video_ary;
	logic                 led_user;

	logic [31:0] rng_state = RNG_SEED;
	int          check_count = 0;
	int          value_errors = 0;
	int          other_errors = 0;

	`include "tb_sysctl_model.svh"

	pcxt_sysctl #(
		.CLK_HZ           (CLK_HZ),
		.CPU_HZ_SLOW      (CPU_HZ_SLOW),
		.CPU_HZ_MID       (450),
		.CPU_HZ_FAST      (900),
		.PERIPH_HZ        (150),
		.AUDIO_HZ         (44),
		.SYS_RESET_CYCLES (SYS_RESET_CYCLES),
		.CPU_RESET_CYCLES (CPU_RESET_CYCLES),
		.SPLASH_SECONDS   (SPLASH_SECONDS),
		.LED_HOLD_CYCLES  (LED_HOLD_CYCLES)
	) u_pcxt_sysctl (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.status        (status),
		.bus_idle      (bus_idle),
		.disk_activity (disk_activity),
		.port_b_bit3   (port_b_bit3),
		.ps2_kbd_in    (ps2_kbd_in),
		.joy_in_0      (joy_in_0),
		.joy_in_1      (joy_in_1),
		.ce_cpu        (ce_cpu),
		.ce_periph     (ce_periph),
		.ce_audio      (ce_audio),
		.turbo         (turbo),
		.cpu_speed     (cpu_speed),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.splash_active (splash_active),
		.model         (model),
		.ps2_kbd_sync  (ps2_kbd_sync),
		.port_c_low    (port_c_low),
		.joy_out_0     (joy_out_0),
		.joy_out_1     (joy_out_1),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.led_user      (led_user)
	);

	// 50 MHz system clock
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Random settings word with splash skip kept low
	function automatic logic [31:0] random_status(input logic [31:0] r);
		r[STATUS_SPLASH_SKIP_BIT] = 1'b0;
		return r;
	endfunction

	// Ends on the edge where reset_wire is released
	task automatic apply_reset();
		@(posedge CLK_50M);
		reset_wire <= 1'b1;
		repeat (RESET_CYCLES) @(posedge CLK_50M);
		reset_wire <= 1'b0;
	endtask

	// Clock edges until the chosen output reads low
	task automatic wait_for_fall(input int which, input string name, input int limit,
	                             output int n);
		logic level;
		n = 0;
		level = 1'b1;
		while (level && (n < limit)) begin
			@(posedge CLK_50M);
			@(negedge CLK_50M);
			n++;
			case (which)
				FALL_SYS_RESET: level = sys_reset;
				FALL_SPLASH:    level = splash_active;
				default:        level = cpu_reset;
			endcase
		end
		if (level) begin
			other_errors++;
			$display("%s did not fall within %0d cycles", name, limit);
		end
	endtask

	// Reset with a random model, then check the reset stretch
	task automatic start_boot();
		logic [31:0] word;
		int          n;
		word = random_status(next_random());
		@(posedge CLK_50M);
		status <= word;
		apply_reset();
		wait_for_fall(FALL_SYS_RESET, "sys_reset", 2 * SYS_RESET_CYCLES, n);
		check_value("sys_reset fall cycle", n, SYS_RESET_CYCLES);
		check_value("model", model, word[STATUS_MODEL_BIT]);
	endtask

	//////////////////////////////////////////////////
	// Test phases
	//////////////////////////////////////////////////

	task automatic boot_timing_test();
		int n;
		start_boot();
		wait_for_fall(FALL_SPLASH, "splash_active", 2 * SPLASH_CYCLES, n);
		check_value("splash_active fall cycle", n, SPLASH_CYCLES);
		wait_for_fall(FALL_CPU_RESET, "cpu_reset", 2 * CPU_RESET_CYCLES, n);
		check_value("cpu_reset fall cycle", n, CPU_RESET_CYCLES);
	endtask

	task automatic splash_skip_test();
		int n;
		int delay;
		delay = 1 + int'(next_random() % SKIP_MAX);
		start_boot();
		repeat (delay) @(posedge CLK_50M);
		status[STATUS_SPLASH_SKIP_BIT] <= 1'b1;
		wait_for_fall(FALL_SPLASH, "splash_active", 2 * SPLASH_CYCLES, n);
		check_value("splash skip latency", n, 1);
		wait_for_fall(FALL_CPU_RESET, "cpu_reset", 2 * CPU_RESET_CYCLES, n);
		check_value("cpu_reset fall after skip", n, CPU_RESET_CYCLES);
	endtask

	// Base speed throughout since the bus is never idle
	task automatic strobe_count_test();
		int window;
		int n_cpu;
		int n_periph;
		int n_audio;
		window = WINDOW_MIN + int'(next_random() % (WINDOW_MAX - WINDOW_MIN + 1));
		n_cpu = 0;
		n_periph = 0;
		n_audio = 0;
		@(posedge CLK_50M);
		status <= random_status(next_random());
		bus_idle <= 1'b0;
		apply_reset();
		repeat (window) begin
			@(negedge CLK_50M);
			n_cpu += int'(ce_cpu);
			n_periph += int'(ce_periph);
			n_audio += int'(ce_audio);
		end
		check_value("ce_cpu count", n_cpu, expected_pulses(window, CPU_HZ_SLOW, CLK_HZ));
		check_value("ce_periph count", n_periph, expected_pulses(window, 150, CLK_HZ));
		check_value("ce_audio count", n_audio, expected_pulses(window, 44, CLK_HZ));
	endtask

	// Speed requests, keyboard, switches, joysticks, aspect and LED
	task automatic random_traffic_test();
		cpu_speed_e  exp_speed;
		ps2_lines_t  ps2_early;
		ps2_lines_t  ps2_late;
		int          since_pulse;
		logic [31:0] r_ctrl;
		logic [31:0] r_joy_a;
		logic [31:0] r_joy_b;
		logic [31:0] r_joy_c;
		exp_speed = SPEED_4_77;
		ps2_early = '0;
		ps2_late = '0;
		since_pulse = LED_HOLD_CYCLES;
		repeat (RANDOM_CYCLES) begin
			@(posedge CLK_50M);
			// Inputs as the DUT samples them on this edge
			if (bus_idle) begin
				exp_speed = cpu_speed_e'(status[STATUS_SPEED_LSB +: 2]);
			end
			ps2_late = ps2_early;
			ps2_early = ps2_kbd_in;
			if (disk_activity) begin
				since_pulse = 0;
			end else if (since_pulse < LED_HOLD_CYCLES) begin
				since_pulse++;
			end
			r_ctrl = next_random();
			r_joy_a = next_random();
			r_joy_b = next_random();
			r_joy_c = next_random();
			status <= random_status(next_random());
			bus_idle <= (r_ctrl[1:0] == 2'b00);
			port_b_bit3 <= r_ctrl[2];
			ps2_kbd_in <= r_ctrl[4:3];
			// Sparse pulses so the LED also goes dark
			disk_activity <= (r_ctrl[9:5] == 5'd0);
			joy_in_0 <= {r_joy_a, r_joy_c[15:0]};
			joy_in_1 <= {r_joy_b, r_joy_c[31:16]};
			@(negedge CLK_50M);
			check_value("cpu_speed", cpu_speed, exp_speed);
			check_value("turbo", turbo, expected_turbo(exp_speed));
			check_value("ps2_kbd_sync", ps2_kbd_sync, ps2_late);
			check_value("port_c_low", port_c_low,
			            dip_nibble(status[STATUS_VIDEO_BIT], port_b_bit3));
			check_value("joy_out_0", joy_out_0, status[STATUS_JOY_SWAP_BIT] ? joy_in_1 : joy_in_0);
			check_value("joy_out_1", joy_out_1, status[STATUS_JOY_SWAP_BIT] ? joy_in_0 : joy_in_1);
			check_value("video_arx", video_arx, aspect_x(status[STATUS_ASPECT_LSB +: 2]));
			check_value("video_ary", video_ary, aspect_y(status[STATUS_ASPECT_LSB +: 2]));
			check_value("led_user", led_user, since_pulse < LED_HOLD_CYCLES);
		end
	endtask

	//////////////////////////////////////////////////
	// Main sequence and watchdog
	//////////////////////////////////////////////////

	initial begin
		reset_wire = 1'b1;
		status = '0;
		bus_idle = 1'b0;
		disk_activity = 1'b0;
		port_b_bit3 = 1'b0;
		ps2_kbd_in = '0;
		joy_in_0 = '0;
		joy_in_1 = '0;
		boot_timing_test();
		splash_skip_test();
		strobe_count_test();
		random_traffic_test();
		$display("Checks: %0d, value errors: %0d, other failures: %0d",
		         check_count, value_errors, other_errors);
		if ((value_errors == 0) && (other_errors == 0)) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
		$display("Watchdog expired, run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: verilog/pcxt_sysctl.sv
// PC/XT system control top level
// Decodes the host status word into machine settings and ties
// together clock enables, boot sequencing and the board glue

`timescale 1ns/1ps

module pcxt_sysctl #(
	parameter int CLK_HZ           = 50_000_000,
	parameter int CPU_HZ_SLOW      = 4_772_727,
	parameter int CPU_HZ_MID       = 7_159_090,
	parameter int CPU_HZ_FAST      = 14_318_180,
	parameter int PERIPH_HZ        = 2_386_364,
	parameter int AUDIO_HZ         = 44_100,
	parameter int SYS_RESET_CYCLES = 65_535,
	parameter int CPU_RESET_CYCLES = 42,
	parameter int SPLASH_SECONDS   = 5,
	parameter int LED_HOLD_CYCLES  = 4_500_000
) (
	input  logic                           CLK_50M,
	input  logic                           reset_wire,
	input  logic [31:0]                    status,
	input  logic                           bus_idle,
	input  logic                           disk_activity,
	input  logic                           port_b_bit3,
	input  board_io_pkg::ps2_lines_t       ps2_kbd_in,
	input  board_io_pkg::joy_port_t        joy_in_0,
	input  board_io_pkg::joy_port_t        joy_in_1,
	output logic                           ce_cpu,
	output logic                           ce_periph,
	output logic                           ce_audio,
	output logic                           turbo,
	output sysctl_cfg_pkg::cpu_speed_e     cpu_speed,
	output logic                           sys_reset,
	output logic                           cpu_reset,
	output logic                           splash_active,
	output sysctl_cfg_pkg::machine_model_e model,
	output board_io_pkg::ps2_lines_t       ps2_kbd_sync,
	output logic [3:0]                     port_c_low,
	output board_io_pkg::joy_port_t        joy_out_0,
	output board_io_pkg::joy_port_t        joy_out_1,
	output logic [board_io_pkg::ASPECT_W-1:0] video_arx,
	output logic [board_io_pkg::ASPECT_W-1:0] video_ary,
	output logic                           led_user
);

	import sysctl_cfg_pkg::*;

	sys_settings_t settings;

	//////////////////////////////////////////////////
	// Status word decode
	//////////////////////////////////////////////////

	always_comb begin
		settings.speed       = cpu_speed_e'(status[STATUS_SPEED_LSB +: 2]);
		settings.model       = machine_model_e'(status[STATUS_MODEL_BIT]);
		settings.video       = video_out_e'(status[STATUS_VIDEO_BIT]);
		settings.aspect      = status[STATUS_ASPECT_LSB +: 2];
		// Menu option "Splash Screen: No"
		settings.splash_skip = status[STATUS_SPLASH_SKIP_BIT];
		settings.joy_swap    = status[STATUS_JOY_SWAP_BIT];
	end

	// CPU, peripheral and audio enables
	clock_enable_gen #(
		.CLK_HZ      (CLK_HZ),
		.CPU_HZ_SLOW (CPU_HZ_SLOW),
		.CPU_HZ_MID  (CPU_HZ_MID),
		.CPU_HZ_FAST (CPU_HZ_FAST),
		.PERIPH_HZ   (PERIPH_HZ),
		.AUDIO_HZ    (AUDIO_HZ)
	) u_clock_enable_gen (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.speed_req  (settings.speed),
		.bus_idle   (bus_idle),
		.ce_cpu     (ce_cpu),
		.ce_periph  (ce_periph),
		.ce_audio   (ce_audio),
		.turbo      (turbo),
		.cpu_speed  (cpu_speed)
	);

	// Reset stretch, splash and CPU hold
	boot_sequencer #(
		.CLK_HZ           (CLK_HZ),
		.SYS_RESET_CYCLES (SYS_RESET_CYCLES),
		.CPU_RESET_CYCLES (CPU_RESET_CYCLES),
		.SPLASH_SECONDS   (SPLASH_SECONDS)
	) u_boot_sequencer (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.model_req     (settings.model),
		.splash_skip   (settings.splash_skip),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.splash_active (splash_active),
		.model         (model)
	);

	board_io #(
		.LED_HOLD_CYCLES (LED_HOLD_CYCLES)
	) u_board_io (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.video         (settings.video),
		.aspect        (settings.aspect),
		.joy_swap      (settings.joy_swap),
		.port_b_bit3   (port_b_bit3),
		.disk_activity (disk_activity),
		.ps2_kbd_in    (ps2_kbd_in),
		.joy_in_0      (joy_in_0),
		.joy_in_1      (joy_in_1),
		.ps2_kbd_sync  (ps2_kbd_sync),
		.port_c_low    (port_c_low),
		.joy_out_0     (joy_out_0),
		.joy_out_1     (joy_out_1),
		.video_arx     (video_arx),
		.video_ary     (video_ary),
		.led_user      (led_user)
	);

endmodule

// File: verilog/board_io.sv
// Board glue
// Keyboard line synchronizers, DIP switch read through port C,
// joystick swap, aspect-ratio outputs and the disk LED stretcher

`timescale 1ns/1ps

module board_io #(
	parameter int LED_HOLD_CYCLES = 4_500_000
) (
	input  logic                         CLK_50M,
	input  logic                         reset_wire,
	input  sysctl_cfg_pkg::video_out_e   video,
	input  logic [1:0]                   aspect,
	input  logic                         joy_swap,
	input  logic                         port_b_bit3,
	input  logic                         disk_activity,
	input  board_io_pkg::ps2_lines_t     ps2_kbd_in,
	input  board_io_pkg::joy_port_t      joy_in_0,
	input  board_io_pkg::joy_port_t      joy_in_1,
	output board_io_pkg::ps2_lines_t     ps2_kbd_sync,
	output logic [3:0]                   port_c_low,
	output board_io_pkg::joy_port_t      joy_out_0,
	output board_io_pkg::joy_port_t      joy_out_1,
	output logic [board_io_pkg::ASPECT_W-1:0] video_arx,
	output logic [board_io_pkg::ASPECT_W-1:0] video_ary,
	output logic                         led_user
);

	import sysctl_cfg_pkg::*;
	import board_io_pkg::*;

	localparam int LED_W = $clog2(LED_HOLD_CYCLES + 1);

	ps2_lines_t       ps2_meta;
	logic [7:0]       dip_sw;
	logic [LED_W-1:0] led_cnt;

	// Two flops on the keyboard clock and data
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			ps2_meta     <= '0;
			ps2_kbd_sync <= '0;
		end else begin
			ps2_meta     <= ps2_kbd_in;
			ps2_kbd_sync <= ps2_meta;
		end
	end

	// Switch bank follows adapter, PB3 picks the nibble
	assign dip_sw     = (video == VIDEO_MDA) ? DIP_SW_MDA : DIP_SW_CGA;
	assign port_c_low = port_b_bit3 ? dip_sw[7:4] : dip_sw[3:0];

	assign joy_out_0 = joy_swap ? joy_in_1 : joy_in_0;
	assign joy_out_1 = joy_swap ? joy_in_0 : joy_in_1;

	// Code 0 is 4:3, others pass the code minus one as a preset index
	assign video_arx = (aspect == 2'd0) ? ASPECT_W'(4) : {{(ASPECT_W-2){1'b0}}, aspect - 2'd1};
	assign video_ary = (aspect == 2'd0) ? ASPECT_W'(3) : '0;

	//////////////////////////////////////////////////
	// Disk LED stretcher
	//////////////////////////////////////////////////

	// Each pulse reloads the hold time
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			led_cnt <= '0;
		end else if (disk_activity) begin
			led_cnt <= LED_W'(LED_HOLD_CYCLES);
		end else if (led_cnt != '0) begin
			led_cnt <= led_cnt - 1'b1;
		end
	end

	assign led_user = (led_cnt != '0);

endmodule

// File: verilog/boot_sequencer.sv
// Boot sequencer
// Stretches the system reset, runs the splash screen timer,
// then holds the CPU in reset a little longer. Latches the model

`timescale 1ns/1ps

module boot_sequencer #(
	parameter int CLK_HZ           = 50_000_000,
	parameter int SYS_RESET_CYCLES = 65_535,
	parameter int CPU_RESET_CYCLES = 42,
	parameter int SPLASH_SECONDS   = 5
) (
	input  logic                        CLK_50M,
	input  logic                        reset_wire,
	input  sysctl_cfg_pkg::machine_model_e model_req,
	input  logic                        splash_skip,
	output logic                        sys_reset,
	output logic                        cpu_reset,
	output logic                        splash_active,
	output sysctl_cfg_pkg::machine_model_e model
);

	import sysctl_cfg_pkg::*;

	typedef enum logic [1:0] {
		BOOT_SYS_RESET,
		BOOT_SPLASH,
		BOOT_CPU_HOLD,
		BOOT_RUN
	} boot_state_e;

	// One counter serves all three phases
	localparam int CNT_MAX_A = (SYS_RESET_CYCLES > CLK_HZ) ? SYS_RESET_CYCLES : CLK_HZ;
	localparam int CNT_MAX   = (CPU_RESET_CYCLES > CNT_MAX_A) ? CPU_RESET_CYCLES : CNT_MAX_A;
	localparam int CNT_W     = $clog2(CNT_MAX + 1);
	localparam int SEC_W     = $clog2(SPLASH_SECONDS + 1);

	// Terminal counts
	localparam logic [CNT_W-1:0] SYS_LAST    = CNT_W'(SYS_RESET_CYCLES - 1);
	localparam logic [CNT_W-1:0] SECOND_LAST = CNT_W'(CLK_HZ - 1);
	localparam logic [CNT_W-1:0] CPU_LAST    = CNT_W'(CPU_RESET_CYCLES - 1);
	localparam logic [SEC_W-1:0] SPLASH_LAST = SEC_W'(SPLASH_SECONDS - 1);

	boot_state_e      state;
	logic [CNT_W-1:0] cycle_cnt;
	logic [SEC_W-1:0] sec_cnt;
	logic             second_done;
	logic             splash_done;

	assign second_done = (cycle_cnt == SECOND_LAST);
	// Timeout on the last cycle of the last second
	assign splash_done = second_done && (sec_cnt == SPLASH_LAST);

	//////////////////////////////////////////////////
	// Sequence FSM
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state     <= BOOT_SYS_RESET;
			cycle_cnt <= '0;
			sec_cnt   <= '0;
			model     <= MODEL_IBM_XT;
		end else begin
			case (state)
				BOOT_SYS_RESET: begin
					if (cycle_cnt == SYS_LAST) begin
						state     <= BOOT_SPLASH;
						cycle_cnt <= '0;
						// Model fixed for the whole session
						model     <= model_req;
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				BOOT_SPLASH: begin
					// User skip wins over the timer
					if (splash_skip || splash_done) begin
						state     <= BOOT_CPU_HOLD;
						cycle_cnt <= '0;
						sec_cnt   <= '0;
					end else if (second_done) begin
						cycle_cnt <= '0;
						sec_cnt   <= sec_cnt + 1'b1;
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				BOOT_CPU_HOLD: begin
					if (cycle_cnt == CPU_LAST) begin
						state <= BOOT_RUN;
					end else begin
						cycle_cnt <= cycle_cnt + 1'b1;
					end
				end
				default: begin
					// Running, stay here until the next reset
					state <= BOOT_RUN;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Outputs decoded from state
	//////////////////////////////////////////////////

	assign sys_reset     = (state == BOOT_SYS_RESET);
	assign splash_active = (state == BOOT_SYS_RESET) || (state == BOOT_SPLASH);
	assign cpu_reset     = (state != BOOT_RUN);

endmodule

// File: verilog/clock_enable_gen.sv
// Clock enable generator
// Three phase accumulators give CPU, peripheral and audio strobes
// from the single system clock. CPU speed changes only at bus idle

`timescale 1ns/1ps

module clock_enable_gen #(
	parameter int CLK_HZ      = 50_000_000,
	parameter int CPU_HZ_SLOW = 4_772_727,
	parameter int CPU_HZ_MID  = 7_159_090,
	parameter int CPU_HZ_FAST = 14_318_180,
	parameter int PERIPH_HZ   = 2_386_364,
	parameter int AUDIO_HZ    = 44_100
) (
	input  logic                    CLK_50M,
	input  logic                    reset_wire,
	input  sysctl_cfg_pkg::cpu_speed_e speed_req,
	input  logic                    bus_idle,
	output logic                    ce_cpu,
	output logic                    ce_periph,
	output logic                    ce_audio,
	output logic                    turbo,
	output sysctl_cfg_pkg::cpu_speed_e cpu_speed
);

	import sysctl_cfg_pkg::*;

	// Sum of a phase and an increment stays below twice the clock rate
	localparam int ACC_W = $clog2(2 * CLK_HZ);
	localparam logic [ACC_W-1:0] LIMIT = ACC_W'(CLK_HZ);

	// Channel slots
	localparam int CH_CPU    = 0;
	localparam int CH_PERIPH = 1;
	localparam int CH_AUDIO  = 2;
	localparam int NUM_CH    = 3;

	cpu_speed_e       applied_speed;
	logic [ACC_W-1:0] cpu_incr;
	logic [ACC_W-1:0] incr [NUM_CH];
	logic [NUM_CH-1:0] strobe;

	//////////////////////////////////////////////////
	// Applied CPU speed
	//////////////////////////////////////////////////

	// Request taken only while the bus is idle
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			applied_speed <= SPEED_4_77;
		end else if (bus_idle) begin
			applied_speed <= speed_req;
		end
	end

	// Reserved code falls back to base rate
	always_comb begin
		case (applied_speed)
			SPEED_7_16:  cpu_incr = ACC_W'(CPU_HZ_MID);
			SPEED_14_32: cpu_incr = ACC_W'(CPU_HZ_FAST);
			default:     cpu_incr = ACC_W'(CPU_HZ_SLOW);
		endcase
	end

	assign incr[CH_CPU]    = cpu_incr;
	assign incr[CH_PERIPH] = ACC_W'(PERIPH_HZ);
	assign incr[CH_AUDIO]  = ACC_W'(AUDIO_HZ);

	//////////////////////////////////////////////////
	// Phase accumulators
	//////////////////////////////////////////////////

	for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_chan
		logic [ACC_W-1:0] acc;
		logic [ACC_W-1:0] sum;

		assign sum = acc + incr[ch];
		// Strobe on the cycle the phase wraps
		assign strobe[ch] = (sum >= LIMIT);

		always_ff @(posedge CLK_50M or posedge reset_wire) begin
			if (reset_wire) begin
				acc <= '0;
			end else if (strobe[ch]) begin
				acc <= sum - LIMIT;
			end else begin
				acc <= sum;
			end
		end
	end

	// Zero phase in reset keeps every strobe low
	assign ce_cpu    = strobe[CH_CPU];
	assign ce_periph = strobe[CH_PERIPH];
	assign ce_audio  = strobe[CH_AUDIO];

	assign cpu_speed = applied_speed;
	assign turbo     = (applied_speed == SPEED_7_16) || (applied_speed == SPEED_14_32);

endmodule

// File: verilog/board_io_pkg.sv
// Board signal group package
// Keyboard line pair, joystick port bundle, DIP switch banks
// and the width of the video aspect-ratio outputs

package board_io_pkg;

	// PS/2 keyboard wire pair
	typedef struct packed {
		logic clk;
		logic data;
	} ps2_lines_t;

	// One joystick port
	// Digital buttons and directions in the upper part
	typedef struct packed {
		logic [31:0] digital;
		logic [15:0] analog;
	} joy_port_t;

	//////////////////////////////////////////////////
	// Motherboard DIP switch banks
	//////////////////////////////////////////////////

	// Color adapter in 80 columns
	localparam logic [7:0] DIP_SW_CGA = 8'h2D;
	// Monochrome adapter
	localparam logic [7:0] DIP_SW_MDA = 8'h3D;

	// Aspect-ratio output width
	// Bit 12 set would mean scaled size rather than ratio
	localparam int ASPECT_W = 13;

endpackage

// File: verilog/sysctl_cfg_pkg.sv
// System control configuration package
// Machine settings decoded from the host status word: CPU speed,
// machine model, video output, and the bit map of the status word

package sysctl_cfg_pkg;

	//////////////////////////////////////////////////
	// Setting encodings
	//////////////////////////////////////////////////

	// CPU clock selection, reserved code runs at base speed
	typedef enum logic [1:0] {
		SPEED_4_77  = 2'd0,
		SPEED_7_16  = 2'd1,
		SPEED_14_32 = 2'd2,
		SPEED_RSVD  = 2'd3
	} cpu_speed_e;

	// BIOS and video personality
	typedef enum logic {
		MODEL_IBM_XT = 1'b0,
		MODEL_TANDY  = 1'b1
	} machine_model_e;

	// Display adapter on the video output
	typedef enum logic {
		VIDEO_CGA = 1'b0,
		VIDEO_MDA = 1'b1
	} video_out_e;

	//////////////////////////////////////////////////
	// Status word bit map
	//////////////////////////////////////////////////

	localparam int STATUS_RESET_BIT       = 0;
	localparam int STATUS_MODEL_BIT       = 3;
	localparam int STATUS_VIDEO_BIT       = 4;
	localparam int STATUS_SPLASH_SKIP_BIT = 7;
	// Two bits each
	localparam int STATUS_ASPECT_LSB      = 8;
	localparam int STATUS_SPEED_LSB       = 17;
	localparam int STATUS_JOY_SWAP_BIT    = 25;

	// Decoded settings, one byte
	typedef struct packed {
		cpu_speed_e     speed;
		machine_model_e model;
		video_out_e     video;
		logic [1:0]     aspect;
		logic           splash_skip;
		logic           joy_swap;
	} sys_settings_t;

endpackage
